//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP       ?= intra4_picker_tb
FILELIST  ?= intra4_picker.f
BUILD_DIR ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- intra4_picker.f
logic/intra4_pkg.sv
logic/intra4_predict.sv
logic/block_sse.sv
logic/mode_decision.sv
logic/neighbor_cache.sv
logic/intra4_control.sv
logic/intra4_picker.sv
verification/intra4_ref_pkg.sv
verification/intra4_picker_tb.sv

//--- logic/block_sse.sv
// Row-serial 4x4 SSE
module block_sse (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  intra4_pkg::blk4_t src_i,
    input  intra4_pkg::blk4_t pred_i,
    output intra4_pkg::sse_t  sse_o,
    output logic              done_o
);

    localparam logic [1:0] LAST_ROW = 2'(intra4_pkg::BLK_ROWS - 1);

    logic             busy;
    logic [1:0]       row;
    intra4_pkg::sse_t acc;
    intra4_pkg::sse_t row_sse;

    always_comb begin : row_err
        int diff;
        row_sse = '0;
        for (int x = 0; x < 4; x++) begin
            diff    = int'(src_i[32*row + 8*x +: 8]) - int'(pred_i[32*row + 8*x +: 8]);
            row_sse = row_sse + intra4_pkg::sse_t'(diff * diff);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            row  <= '0;
            acc  <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            row  <= '0;
            acc  <= '0;
        end else if (busy) begin
            acc <= acc + row_sse;
            row <= row + 2'd1;
            if (row == LAST_ROW) begin
                busy <= 1'b0;
            end
        end
    end

    // Last row is added on the fly
    assign done_o = busy && (row == LAST_ROW);
    assign sse_o  = acc + row_sse;

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> ##4 done_o);
    a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> $past(start_i, 4));

endmodule

//--- logic/intra4_control.sv
// Intra 4x4 sequencer
module intra4_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  intra4_pkg::mb_t         src_i,
    input  intra4_pkg::lambda_t     lambda_mode_i,
    input  intra4_pkg::pred_set_t   pred_i,
    input  logic                    sse_done_i,
    input  intra4_pkg::pred_mode_e  best_mode_i,
    input  intra4_pkg::score_t      best_score_i,
    output logic                    load_o,
    output logic                    advance_o,
    output logic [3:0]              sub_idx_o,
    output intra4_pkg::blk4_t       chosen_o,
    output intra4_pkg::blk4_t       cur_src_o,
    output intra4_pkg::pred_set_t   cur_pred_o,
    output logic                    sse_start_o,
    output intra4_pkg::lambda_t     lambda_o,
    output intra4_pkg::mb_t         yout_o,
    output intra4_pkg::score_t      score_o,
    output intra4_pkg::mode_map_t   modes_o,
    output logic                    done_o
);

    typedef enum logic [2:0] {
        IDLE, LOAD, PRED, WAIT, STORE, ADVANCE, DONE
    } state_e;

    localparam int ROW_BITS = 8 * intra4_pkg::MB_DIM;

    state_e                 state;
    state_e                 state_nxt;
    intra4_pkg::mb_t        src_r;
    intra4_pkg::pred_mode_e best_mode_r;
    intra4_pkg::score_t     best_score_r;
    logic [10:0]            mb_base;

    // Bit offset of the current sub-block's first pixel
    assign mb_base = 11'(4 * ROW_BITS * int'(sub_idx_o[3:2]) + 32 * int'(sub_idx_o[1:0]));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start_i) state_nxt = LOAD;
            LOAD:    state_nxt = PRED;
            PRED:    state_nxt = WAIT;
            WAIT:    if (sse_done_i) state_nxt = STORE;
            STORE:   state_nxt = ADVANCE;
            ADVANCE: begin
                if (sub_idx_o == 4'(intra4_pkg::NUM_SUBBLOCKS - 1)) begin
                    state_nxt = DONE;
                end else begin
                    state_nxt = PRED;
                end
            end
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Edges are captured on the accepted start itself
    assign load_o      = (state == IDLE) && start_i;
    assign sse_start_o = (state == PRED);
    assign advance_o   = (state == ADVANCE);
    assign done_o      = (state == DONE);

    always_comb begin
        case (best_mode_r)
            intra4_pkg::MODE_DC: chosen_o = cur_pred_o.dc;
            intra4_pkg::MODE_TM: chosen_o = cur_pred_o.tm;
            intra4_pkg::MODE_VE: chosen_o = cur_pred_o.ve;
            default:             chosen_o = cur_pred_o.he;
        endcase
    end

    //--------------------------------------------------------------------------
    // Control and result registers
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            sub_idx_o    <= '0;
            lambda_o     <= '0;
            best_mode_r  <= intra4_pkg::MODE_DC;
            best_score_r <= '0;
            yout_o       <= '0;
            score_o      <= '0;
            modes_o      <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        lambda_o <= lambda_mode_i;
                    end
                end
                LOAD: begin
                    sub_idx_o <= '0;
                    score_o   <= intra4_pkg::score_t'(intra4_pkg::MB_BASE_COST)
                                 * intra4_pkg::score_t'(lambda_o);
                end
                WAIT: begin
                    if (sse_done_i) begin
                        best_mode_r  <= best_mode_i;
                        best_score_r <= best_score_i;
                    end
                end
                STORE: begin
                    for (int y = 0; y < intra4_pkg::BLK_ROWS; y++) begin
                        yout_o[mb_base + ROW_BITS*y +: 32] <= chosen_o[32*y +: 32];
                    end
                    modes_o[2*sub_idx_o +: 2] <= best_mode_r;
                    score_o <= score_o + best_score_r;
                end
                ADVANCE: sub_idx_o <= sub_idx_o + 4'd1;
                default: ;
            endcase
        end
    end

    // Source macroblock and the block under test
    always_ff @(posedge clk) begin
        if (load_o) begin
            src_r <= src_i;
        end
        if (state == PRED) begin
            cur_pred_o <= pred_i;
            for (int y = 0; y < intra4_pkg::BLK_ROWS; y++) begin
                cur_src_o[32*y +: 32] <= src_r[mb_base + ROW_BITS*y +: 32];
            end
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o);
    a_sse_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        sse_done_i |-> (state == WAIT));

endmodule

//--- logic/intra4_picker.sv
// Intra 4x4 mode picker
module intra4_picker #(
    parameter int DIST_SHIFT = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    input  intra4_pkg::mb_t                        src_i,
    input  logic [8*intra4_pkg::TOP_PIX-1:0]       top_i,
    input  intra4_pkg::pixel_t                     top_left_i,
    input  logic [8*intra4_pkg::MB_DIM-1:0]        left_i,
    input  intra4_pkg::lambda_t                    lambda_mode_i,
    output intra4_pkg::mb_t                        yout_o,
    output intra4_pkg::score_t                     score_o,
    output intra4_pkg::mode_map_t                  modes_o,
    output logic                                   done_o
);

    localparam int BLK_W = $bits(intra4_pkg::blk4_t);

    logic                           load;
    logic                           advance;
    logic                           sse_start;
    logic                           sse_done;
    logic [3:0]                     sub_idx;
    intra4_pkg::blk4_t              chosen;
    intra4_pkg::blk4_t              cur_src;
    intra4_pkg::pred_set_t          pred;
    intra4_pkg::pred_set_t          cur_pred;
    intra4_pkg::nbr_t               nbr;
    intra4_pkg::lambda_t            lambda;
    intra4_pkg::pred_mode_e         best_mode;
    intra4_pkg::score_t             best_score;
    intra4_pkg::sse_t               sse_arr [intra4_pkg::NUM_MODES];
    wire [intra4_pkg::NUM_MODES-1:0] sse_done_vec;
    intra4_pkg::sse_set_t           sse_set;

    assign sse_set  = {sse_arr[3], sse_arr[2], sse_arr[1], sse_arr[0]};
    assign sse_done = &sse_done_vec;

    intra4_control intra4_control_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .src_i         (src_i),
        .lambda_mode_i (lambda_mode_i),
        .pred_i        (pred),
        .sse_done_i    (sse_done),
        .best_mode_i   (best_mode),
        .best_score_i  (best_score),
        .load_o        (load),
        .advance_o     (advance),
        .sub_idx_o     (sub_idx),
        .chosen_o      (chosen),
        .cur_src_o     (cur_src),
        .cur_pred_o    (cur_pred),
        .sse_start_o   (sse_start),
        .lambda_o      (lambda),
        .yout_o        (yout_o),
        .score_o       (score_o),
        .modes_o       (modes_o),
        .done_o        (done_o)
    );

    neighbor_cache neighbor_cache_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_i     (load),
        .advance_i  (advance),
        .sub_idx_i  (sub_idx),
        .chosen_i   (chosen),
        .top_i      (top_i),
        .top_left_i (top_left_i),
        .left_i     (left_i),
        .nbr_o      (nbr)
    );

    intra4_predict intra4_predict_inst (
        .nbr_i  (nbr),
        .pred_o (pred)
    );

    // One SSE unit per mode
    for (genvar m = 0; m < intra4_pkg::NUM_MODES; m++) begin : g_sse
        block_sse block_sse_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .start_i (sse_start),
            .src_i   (cur_src),
            .pred_i  (cur_pred[m*BLK_W +: BLK_W]),
            .sse_o   (sse_arr[m]),
            .done_o  (sse_done_vec[m])
        );
    end

    mode_decision #(
        .DIST_SHIFT (DIST_SHIFT)
    ) mode_decision_inst (
        .sse_i        (sse_set),
        .lambda_i     (lambda),
        .best_mode_o  (best_mode),
        .best_score_o (best_score)
    );

endmodule

//--- logic/intra4_pkg.sv
// Intra 4x4 shared definitions
package intra4_pkg;

    //--------------------------------------------------------------------------
    // Geometry and scoring constants
    //--------------------------------------------------------------------------
    localparam int NUM_MODES     = 4;
    localparam int NUM_SUBBLOCKS = 16;
    localparam int MB_DIM        = 16;
    localparam int TOP_PIX       = 20;
    localparam int BLK_ROWS      = 4;
    localparam int MB_BASE_COST  = 211;

    // Header cost per mode, indexed by pred_mode_e
    localparam int unsigned FIXED_COST [NUM_MODES] = '{40, 1151, 1723, 1874};

    //--------------------------------------------------------------------------
    // Data types
    //--------------------------------------------------------------------------
    typedef logic [7:0]                    pixel_t;
    typedef logic [31:0]                   row4_t;
    typedef logic [127:0]                  blk4_t;
    typedef logic [8*MB_DIM*MB_DIM-1:0]    mb_t;
    typedef logic [31:0]                   sse_t;
    typedef logic [63:0]                   score_t;
    typedef logic [31:0]                   lambda_t;
    typedef logic [2*NUM_SUBBLOCKS-1:0]    mode_map_t;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } pred_mode_e;

    typedef struct packed {
        pixel_t top_left;
        row4_t  top;
        row4_t  top_right;
        row4_t  left;
    } nbr_t;

    // DC sits in the low bits so a mode index selects its slice
    typedef struct packed {
        blk4_t he;
        blk4_t ve;
        blk4_t tm;
        blk4_t dc;
    } pred_set_t;

    typedef struct packed {
        sse_t he;
        sse_t ve;
        sse_t tm;
        sse_t dc;
    } sse_set_t;

endpackage

//--- logic/intra4_predict.sv
// Intra 4x4 predictors
module intra4_predict (
    input  intra4_pkg::nbr_t      nbr_i,
    output intra4_pkg::pred_set_t pred_o
);

    // Three tap smoothing (a + 2b + c + 2) / 4
    function automatic intra4_pkg::pixel_t avg3(
        input intra4_pkg::pixel_t a,
        input intra4_pkg::pixel_t b,
        input intra4_pkg::pixel_t c
    );
        logic [9:0] sum;
        sum = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
        return sum[9:2];
    endfunction

    function automatic intra4_pkg::pixel_t clip8(input int v);
        if (v < 0) begin
            return '0;
        end
        if (v > 255) begin
            return 8'd255;
        end
        return intra4_pkg::pixel_t'(v);
    endfunction

    // Edge lines with the corner in front
    intra4_pkg::pixel_t top_ext  [6];
    intra4_pkg::pixel_t left_ext [6];
    logic [10:0]        dc_sum;
    intra4_pkg::pixel_t dc_val;

    always_comb begin
        top_ext[0]  = nbr_i.top_left;
        left_ext[0] = nbr_i.top_left;
        for (int i = 0; i < 4; i++) begin
            top_ext[i+1]  = nbr_i.top[8*i +: 8];
            left_ext[i+1] = nbr_i.left[8*i +: 8];
        end
        top_ext[5]  = nbr_i.top_right[7:0];
        // l3 repeated, gives (l2 + 3*l3 + 2) / 4 on the last row
        left_ext[5] = nbr_i.left[31:24];
    end

    always_comb begin
        dc_sum = 11'd4;
        for (int i = 1; i < 5; i++) begin
            dc_sum = dc_sum + top_ext[i] + left_ext[i];
        end
    end

    assign dc_val = dc_sum[10:3];

    always_comb begin
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                pred_o.dc[32*y + 8*x +: 8] = dc_val;
                pred_o.tm[32*y + 8*x +: 8] = clip8(int'(top_ext[x+1]) + int'(left_ext[y+1])
                                                   - int'(nbr_i.top_left));
                pred_o.ve[32*y + 8*x +: 8] = avg3(top_ext[x], top_ext[x+1], top_ext[x+2]);
                pred_o.he[32*y + 8*x +: 8] = avg3(left_ext[y], left_ext[y+1], left_ext[y+2]);
            end
        end
    end

endmodule

//--- logic/mode_decision.sv
// Mode scoring and selection
module mode_decision #(
    parameter int DIST_SHIFT = 8
) (
    input  intra4_pkg::sse_set_t   sse_i,
    input  intra4_pkg::lambda_t    lambda_i,
    output intra4_pkg::pred_mode_e best_mode_o,
    output intra4_pkg::score_t     best_score_o
);

    localparam int SSE_W = $bits(intra4_pkg::sse_t);

    intra4_pkg::score_t score [intra4_pkg::NUM_MODES];

    // Distortion plus header cost for every mode
    always_comb begin
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            score[m] = (intra4_pkg::score_t'(sse_i[m*SSE_W +: SSE_W]) << DIST_SHIFT)
                     + intra4_pkg::score_t'(intra4_pkg::FIXED_COST[m])
                       * intra4_pkg::score_t'(lambda_i);
        end
    end

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best_mode_o  = intra4_pkg::MODE_DC;
        best_score_o = score[0];
        for (int m = 1; m < intra4_pkg::NUM_MODES; m++) begin
            if (score[m] < best_score_o) begin
                best_mode_o  = intra4_pkg::pred_mode_e'(m);
                best_score_o = score[m];
            end
        end
    end

endmodule

//--- logic/neighbor_cache.sv
// Sub-block neighbor cache
module neighbor_cache (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   load_i,
    input  logic                                   advance_i,
    input  logic [3:0]                             sub_idx_i,
    input  intra4_pkg::blk4_t                      chosen_i,
    input  logic [8*intra4_pkg::TOP_PIX-1:0]       top_i,
    input  intra4_pkg::pixel_t                     top_left_i,
    input  logic [8*intra4_pkg::MB_DIM-1:0]        left_i,
    output intra4_pkg::nbr_t                       nbr_o
);

    logic [8*intra4_pkg::MB_DIM-1:0] top_line;
    logic [8*intra4_pkg::MB_DIM-1:0] mb_left;
    intra4_pkg::row4_t               mb_top_right;
    intra4_pkg::row4_t               cur_left;
    intra4_pkg::pixel_t              cur_top_left;
    intra4_pkg::row4_t               right_col;
    logic [1:0]                      col;
    logic [1:0]                      row;
    logic [1:0]                      next_col;
    logic [1:0]                      next_row;

    assign col      = sub_idx_i[1:0];
    assign row      = sub_idx_i[3:2];
    assign next_col = col + 2'd1;
    assign next_row = row + 2'd1;

    always_comb begin
        for (int y = 0; y < 4; y++) begin
            right_col[8*y +: 8] = chosen_i[32*y + 24 +: 8];
        end
    end

    // Right column takes the macroblock top-right
    always_comb begin
        nbr_o.top_left  = cur_top_left;
        nbr_o.top       = top_line[32*col +: 32];
        nbr_o.top_right = (col == 2'd3) ? mb_top_right : top_line[32*next_col +: 32];
        nbr_o.left      = cur_left;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_line     <= '0;
            mb_left      <= '0;
            mb_top_right <= '0;
            cur_left     <= '0;
            cur_top_left <= '0;
        end else if (load_i) begin
            top_line     <= top_i[8*intra4_pkg::MB_DIM-1:0];
            mb_top_right <= top_i[8*intra4_pkg::TOP_PIX-1 -: 32];
            mb_left      <= left_i;
            cur_left     <= left_i[31:0];
            cur_top_left <= top_left_i;
        end else if (advance_i) begin
            top_line[32*col +: 32] <= chosen_i[127 -: 32];
            if (col == 2'd3) begin
                // Wrap to the start of the next block row
                cur_left     <= mb_left[32*next_row +: 32];
                cur_top_left <= mb_left[32*row + 24 +: 8];
            end else begin
                cur_left     <= right_col;
                cur_top_left <= top_line[32*col + 24 +: 8];
            end
        end
    end

    a_load_advance_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_i && advance_i));

endmodule

//--- verification/intra4_picker_tb.sv
// Intra 4x4 picker testbench
module intra4_picker_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DIST_SHIFT   = 8;
    localparam int RUN_CYCLES   = 114;
    localparam int DONE_TIMEOUT = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  start_i;
    intra4_pkg::mb_t       src_i;
    logic [159:0]          top_i;
    intra4_pkg::pixel_t    top_left_i;
    logic [127:0]          left_i;
    intra4_pkg::lambda_t   lambda_mode_i;
    intra4_pkg::mb_t       yout_o;
    intra4_pkg::score_t    score_o;
    intra4_pkg::mode_map_t modes_o;
    logic                  done_o;

    // Expected results and run bookkeeping
    string                 test_name;
    intra4_pkg::mb_t       exp_yout;
    intra4_pkg::mode_map_t exp_modes;
    intra4_pkg::score_t    exp_score;
    longint                ref_sse;
    logic                  idle_check;
    logic                  start_fresh;
    int                    since_start;
    integer                seed;

    intra4_picker #(
        .DIST_SHIFT (DIST_SHIFT)
    ) intra4_picker_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .src_i         (src_i),
        .top_i         (top_i),
        .top_left_i    (top_left_i),
        .left_i        (left_i),
        .lambda_mode_i (lambda_mode_i),
        .yout_o        (yout_o),
        .score_o       (score_o),
        .modes_o       (modes_o),
        .done_o        (done_o)
    );

    always #20 clk = ~clk;

    // Cycles since the last accepted start
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_start <= 0;
        end else if (start_fresh) begin
            since_start <= 1;
        end else if (since_start != 0) begin
            since_start <= since_start + 1;
        end
    end

    task automatic fail_value(input string field, input string exp_s, input string act_s);
        $display("FAILED %s %s expected %s actual %s", test_name, field, exp_s, act_s);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_idle_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        idle_check |-> (!done_o && score_o == '0 && modes_o == '0 && yout_o == '0))
        else fail_value("idle outputs", "done 0 score 0 modes 0 yout 0",
            $sformatf("done %b score %h modes %h yout %h", $sampled(done_o),
                      $sampled(score_o), $sampled(modes_o), $sampled(yout_o)));

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> (since_start == RUN_CYCLES))
        else fail_value("done latency", $sformatf("%0d", RUN_CYCLES),
                        $sformatf("%0d", $sampled(since_start)));

    a_yout: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> (yout_o == exp_yout))
        else fail_value("yout", $sformatf("%h", exp_yout), $sformatf("%h", $sampled(yout_o)));

    a_modes: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> (modes_o == exp_modes))
        else fail_value("modes", $sformatf("%h", exp_modes), $sformatf("%h", $sampled(modes_o)));

    a_score: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> (score_o == exp_score))
        else fail_value("score", $sformatf("%0d", exp_score),
                        $sformatf("%0d", $sampled(score_o)));

    // ------------------------------------------------------------------------
    // Stimulus helpers entered on a falling edge
    // ------------------------------------------------------------------------
    task automatic pulse_start(input logic fresh);
        start_i     = 1'b1;
        start_fresh = fresh;
        idle_check  = 1'b0;
        @(negedge clk);
        start_i     = 1'b0;
        start_fresh = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_o !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_o !== 1'b1) begin
            $display("%s: done_o never came within %0d cycles", test_name, DONE_TIMEOUT);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end else begin
            // Checks sample the done cycle on the next rising edge
            @(negedge clk);
        end
    endtask

    task automatic random_inputs();
        for (int i = 0; i < 64; i++) begin
            src_i[32*i +: 32] = $random(seed);
        end
        for (int i = 0; i < 5; i++) begin
            top_i[32*i +: 32] = $random(seed);
        end
        for (int i = 0; i < 4; i++) begin
            left_i[32*i +: 32] = $random(seed);
        end
        top_left_i    = 8'($random(seed));
        lambda_mode_i = intra4_pkg::lambda_t'($unsigned($random(seed)) % 256);
    endtask

    task automatic expect_from_model();
        intra4_ref_pkg::run_mb(src_i, top_i, top_left_i, left_i, lambda_mode_i, DIST_SHIFT,
                               exp_yout, exp_modes, exp_score, ref_sse);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        start_i       = 1'b0;
        src_i         = '0;
        top_i         = '0;
        top_left_i    = '0;
        left_i        = '0;
        lambda_mode_i = '0;
        start_fresh   = 1'b0;
        idle_check    = 1'b0;
        exp_yout      = '0;
        exp_modes     = '0;
        exp_score     = '0;
        ref_sse       = 0;
        seed          = 32'h537f;
        test_name     = "reset";
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        test_name  = "idle";
        idle_check = 1'b1;
        repeat (8) @(negedge clk);

        // Flat picture where DC wins everywhere
        test_name     = "flat";
        src_i         = {256{8'd100}};
        top_i         = {20{8'd100}};
        top_left_i    = 8'd100;
        left_i        = {16{8'd100}};
        lambda_mode_i = 32'd5;
        exp_yout      = {256{8'd100}};
        exp_modes     = '0;
        exp_score     = intra4_pkg::score_t'(211 * 5 + 16 * 40 * 5);
        pulse_start(1'b1);
        wait_done();

        for (int n = 0; n < 10; n++) begin
            test_name = $sformatf("random %0d", n);
            random_inputs();
            expect_from_model();
            pulse_start(1'b1);
            wait_done();
        end

        // Column ramp with odd rows one higher so TM and VE predict alike
        test_name = "tie";
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                src_i[8*(16*y + x) +: 8] = 8'(4*x + 10 + y % 2);
            end
        end
        for (int i = 0; i < 20; i++) begin
            top_i[8*i +: 8] = 8'(4*i + 10);
        end
        top_left_i    = 8'd6;
        left_i        = {16{8'd6}};
        lambda_mode_i = '0;
        expect_from_model();
        exp_modes = {16{intra4_pkg::MODE_TM}};
        exp_score = intra4_pkg::score_t'(ref_sse) << DIST_SHIFT;
        pulse_start(1'b1);
        wait_done();

        // Start while busy must not restart or add a done pulse
        test_name = "busy";
        random_inputs();
        expect_from_model();
        pulse_start(1'b1);
        repeat (50) @(negedge clk);
        random_inputs();
        pulse_start(1'b0);
        wait_done();
        repeat (RUN_CYCLES + 16) @(negedge clk);

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verification/intra4_ref_pkg.sv
// Intra 4x4 reference model
package intra4_ref_pkg;

    localparam int MODE_COST [4] = '{40, 1151, 1723, 1874};
    localparam int BASE_COST     = 211;

    function automatic int smooth3(input int a, input int b, input int c);
        return (a + 2 * b + c + 2) / 4;
    endfunction

    function automatic int clip255(input int v);
        if (v < 0) begin
            return 0;
        end
        if (v > 255) begin
            return 255;
        end
        return v;
    endfunction

    // Picture with a one pixel border, pic[0][0] is the corner
    task automatic run_mb(
        input  intra4_pkg::mb_t       src,
        input  logic [159:0]          top,
        input  intra4_pkg::pixel_t    top_left,
        input  logic [127:0]          left,
        input  intra4_pkg::lambda_t   lambda,
        input  int                    dist_shift,
        output intra4_pkg::mb_t       yout,
        output intra4_pkg::mode_map_t modes,
        output intra4_pkg::score_t    score,
        output longint                sse_sum
    );
        int                 pic [17][21];
        int                 pred [4][4][4];
        int                 tx [6];
        int                 lx [6];
        int                 r;
        int                 c;
        int                 dc;
        int                 d;
        int                 best;
        longint             sse;
        longint             best_sse;
        intra4_pkg::score_t cost;
        intra4_pkg::score_t best_cost;

        pic[0][0] = int'(top_left);
        for (int i = 0; i < 20; i++) begin
            pic[0][i + 1] = int'(top[8*i +: 8]);
        end
        for (int i = 0; i < 16; i++) begin
            pic[i + 1][0] = int'(left[8*i +: 8]);
        end
        yout     = '0;
        modes    = '0;
        sse_sum  = 0;
        best_sse = 0;
        score    = intra4_pkg::score_t'(BASE_COST) * intra4_pkg::score_t'(lambda);

        for (int b = 0; b < 16; b++) begin
            r = b / 4;
            c = b % 4;
            tx[0] = pic[4*r][4*c];
            lx[0] = pic[4*r][4*c];
            for (int i = 0; i < 4; i++) begin
                tx[i + 1] = pic[4*r][4*c + 1 + i];
                lx[i + 1] = pic[4*r + 1 + i][4*c];
            end
            // Last block column always sees the macroblock top-right
            tx[5] = (c == 3) ? int'(top[8*16 +: 8]) : pic[4*r][4*c + 5];
            lx[5] = lx[4];
            dc = (tx[1] + tx[2] + tx[3] + tx[4] + lx[1] + lx[2] + lx[3] + lx[4] + 4) / 8;

            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    pred[0][y][x] = dc;
                    pred[1][y][x] = clip255(tx[x + 1] + lx[y + 1] - tx[0]);
                    pred[2][y][x] = smooth3(tx[x], tx[x + 1], tx[x + 2]);
                    pred[3][y][x] = smooth3(lx[y], lx[y + 1], lx[y + 2]);
                end
            end

            best      = 0;
            best_cost = '0;
            for (int m = 0; m < 4; m++) begin
                sse = 0;
                for (int y = 0; y < 4; y++) begin
                    for (int x = 0; x < 4; x++) begin
                        d   = int'(src[8*(16*(4*r + y) + 4*c + x) +: 8]) - pred[m][y][x];
                        sse = sse + longint'(d * d);
                    end
                end
                cost = (intra4_pkg::score_t'(sse) << dist_shift)
                     + intra4_pkg::score_t'(MODE_COST[m]) * intra4_pkg::score_t'(lambda);
                if (m == 0 || cost < best_cost) begin
                    best      = m;
                    best_cost = cost;
                    best_sse  = sse;
                end
            end

            // Chosen prediction doubles as the reconstruction
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    pic[4*r + 1 + y][4*c + 1 + x] = pred[best][y][x];
                    yout[8*(16*(4*r + y) + 4*c + x) +: 8] = 8'(pred[best][y][x]);
                end
            end
            modes[2*b +: 2] = 2'(best);
            score   = score + best_cost;
            sse_sum = sse_sum + best_sse;
        end
    endtask

endpackage
